// ==== hw/rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Integer register file size, x0 included
`define RV_NUM_REGS 32

// Data memory depth in 32-bit words
// Byte addresses wrap at 4 * RV_DMEM_WORDS
`define RV_DMEM_WORDS 64

// Word index width into the data memory
`define RV_DMEM_AW 6

// Cycles from a sampled instr_valid to the output strobes
// Decode, execute and result each add one register stage
`define RV_PIPE_LATENCY 3

`endif

// ==== hw/rv_core_pkg.sv ====
package rv_core_pkg;

   // Major opcodes of the supported subset
   typedef enum logic [6:0] {
      OP_REG    = 7'b0110011,
      OP_IMM    = 7'b0010011,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_BRANCH = 7'b1100011
   } opcode_e;

   // One view per instruction format, fields from bit 31 down
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;   // imm[11:5]
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;   // imm[4:0]
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } b_fmt_t;

   // Same word, four decodings
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
      s_fmt_t s_fmt;
      b_fmt_t b_fmt;
   } instr_u;

   typedef enum logic [2:0] {
      OPC_ALU_R, OPC_ALU_I, OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_ILLEGAL
   } op_class_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
      ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
   } alu_op_e;

   // Branch conditions by funct3
   typedef enum logic [2:0] {
      BR_EQ = 3'b000, BR_NE = 3'b001, BR_LT = 3'b100,
      BR_GE = 3'b101, BR_LTU = 3'b110, BR_GEU = 3'b111
   } br_cond_e;

   // Access size in funct3[1:0], funct3[2] marks an unsigned load
   typedef enum logic [1:0] {
      MEM_B = 2'b00, MEM_H = 2'b01, MEM_W = 2'b10
   } mem_size_e;

   typedef struct packed {
      logic        valid;
      op_class_e   cls;
      alu_op_e     alu_op;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [31:0] imm;     // Sign-extended, B offset in bytes
   } dec_op_t;

   typedef struct packed {
      logic        valid;
      op_class_e   cls;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [31:0] value;   // ALU result or memory byte address
      logic [31:0] store_data;
      logic        taken;
      logic [31:0] offset;
   } exe_res_t;

   typedef struct packed {
      logic        valid;
      logic [4:0]  rd;
      logic [31:0] data;
   } wb_t;

endpackage

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import rv_core_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    instr_valid,
   input  instr_u  instr,
   output dec_op_t dec
);

   dec_op_t nxt;
   dec_op_t op_q;     // Decoded fields, loaded only with a valid word
   logic    valid_q;

   // funct3 to ALU op, bit 30 picks SUB or SRA
   // Immediate ops never take SUB since bit 30 is part of the immediate there
   function automatic alu_op_e alu_map(input logic [2:0] f3,
                                       input logic       alt,
                                       input logic       sub_ok);
      alu_op_e op;
      case (f3)
         3'b000:  op = (alt && sub_ok) ? ALU_SUB : ALU_ADD;
         3'b001:  op = ALU_SLL;
         3'b010:  op = ALU_SLT;
         3'b011:  op = ALU_SLTU;
         3'b100:  op = ALU_XOR;
         3'b101:  op = alt ? ALU_SRA : ALU_SRL;
         3'b110:  op = ALU_OR;
         default: op = ALU_AND;
      endcase
      return op;
   endfunction

   always_comb begin
      nxt        = '0;
      nxt.cls    = OPC_ILLEGAL;
      nxt.alu_op = ALU_ADD;             // Loads and stores use the adder
      nxt.funct3 = instr.r_fmt.funct3;  // Common fields sit at the same bits
      nxt.rd     = instr.r_fmt.rd;
      nxt.rs1    = instr.r_fmt.rs1;
      nxt.rs2    = instr.r_fmt.rs2;
      case (instr.r_fmt.opcode)
         OP_REG: begin
            nxt.cls    = OPC_ALU_R;
            nxt.alu_op = alu_map(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b1);
         end
         OP_IMM: begin
            nxt.cls    = OPC_ALU_I;
            nxt.imm    = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            nxt.alu_op = alu_map(instr.i_fmt.funct3, instr.i_fmt.imm[10], 1'b0);
         end
         OP_LOAD: begin
            nxt.cls = OPC_LOAD;
            nxt.imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
         end
         OP_STORE: begin
            nxt.cls = OPC_STORE;
            nxt.imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi,
                       instr.s_fmt.imm_lo};
         end
         OP_BRANCH: begin
            nxt.cls = OPC_BRANCH;
            // Offset bits 12..1, bit 0 always zero
            nxt.imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
                       instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                       instr.b_fmt.imm_4_1, 1'b0};
         end
         default: nxt.cls = OPC_ILLEGAL;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= instr_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (instr_valid) begin
         op_q <= nxt;
      end
   end

   always_comb begin
      dec       = op_q;
      dec.valid = valid_q;
   end

endmodule

// ==== hw/execute_unit.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module execute_unit import rv_core_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  dec_op_t  dec,
   input  wb_t      wb,
   output exe_res_t exe
);

   logic [31:0] regs [`RV_NUM_REGS];
   logic [31:0] rs1_val;
   logic [31:0] rs2_val;
   logic [31:0] op_b;
   logic [31:0] alu_res;
   logic        taken;
   exe_res_t    nxt;
   exe_res_t    res_q;
   logic        valid_q;

   // Own result register wins over the writeback in flight
   // A load result reaches the bypass only through wb one slot later
   function automatic logic [31:0] bypass(input logic [4:0]  idx,
                                          input logic [31:0] rf_val,
                                          input exe_res_t    ex,
                                          input wb_t         w);
      logic ex_alu;
      ex_alu = ex.valid && (ex.cls == OPC_ALU_R || ex.cls == OPC_ALU_I);
      if (idx == 5'd0) begin
         return '0;   // x0 reads zero
      end else if (ex_alu && ex.rd == idx) begin
         return ex.value;
      end else if (w.valid && w.rd == idx) begin
         return w.data;
      end
      return rf_val;
   endfunction

   // Architectural registers clear at reset and x0 is never written
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `RV_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid && wb.rd != 5'd0) begin
         regs[wb.rd] <= wb.data;
      end
   end

   always_comb begin
      rs1_val = bypass(dec.rs1, regs[dec.rs1], exe, wb);
      rs2_val = bypass(dec.rs2, regs[dec.rs2], exe, wb);
   end

   assign op_b = (dec.cls == OPC_ALU_R) ? rs2_val : dec.imm;

   always_comb begin
      case (dec.alu_op)
         ALU_SUB:  alu_res = rs1_val - op_b;
         ALU_SLL:  alu_res = rs1_val << op_b[4:0];
         ALU_SLT:  alu_res = {31'b0, $signed(rs1_val) < $signed(op_b)};
         ALU_SLTU: alu_res = {31'b0, rs1_val < op_b};
         ALU_XOR:  alu_res = rs1_val ^ op_b;
         ALU_SRL:  alu_res = rs1_val >> op_b[4:0];
         ALU_SRA:  alu_res = $unsigned($signed(rs1_val) >>> op_b[4:0]);
         ALU_OR:   alu_res = rs1_val | op_b;
         ALU_AND:  alu_res = rs1_val & op_b;
         default:  alu_res = rs1_val + op_b;
      endcase
   end

   always_comb begin
      case (br_cond_e'(dec.funct3))
         BR_EQ:   taken = (rs1_val == rs2_val);
         BR_NE:   taken = (rs1_val != rs2_val);
         BR_LT:   taken = ($signed(rs1_val) < $signed(rs2_val));
         BR_GE:   taken = ($signed(rs1_val) >= $signed(rs2_val));
         BR_LTU:  taken = (rs1_val < rs2_val);
         BR_GEU:  taken = (rs1_val >= rs2_val);
         default: taken = 1'b0;   // Reserved conditions never branch
      endcase
   end

   always_comb begin
      nxt            = '0;
      nxt.cls        = dec.cls;
      nxt.funct3     = dec.funct3;
      nxt.rd         = dec.rd;
      nxt.value      = alu_res;   // Loads and stores get rs1 plus imm from the adder
      nxt.store_data = rs2_val;
      nxt.taken      = taken;
      nxt.offset     = dec.imm;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= dec.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (dec.valid) begin
         res_q <= nxt;
      end
   end

   always_comb begin
      exe       = res_q;
      exe.valid = valid_q;
   end

endmodule

// ==== hw/result_unit.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module result_unit import rv_core_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  exe_res_t    exe,
   output wb_t         wb,
   output logic        br_valid,
   output logic        br_taken,
   output logic [31:0] br_offset,
   output logic        illegal
);

   logic [31:0]           mem [`RV_DMEM_WORDS];
   logic [`RV_DMEM_AW-1:0] word_idx;
   logic [1:0]            byte_off;
   logic [3:0]            byte_en;
   logic [31:0]           wdata;
   logic [31:0]           rdata;
   logic [31:0]           lane;
   logic [31:0]           ld_val;
   logic                  is_store;
   logic                  wb_en;
   logic                  wb_valid_q;
   logic [4:0]            wb_rd_q;
   logic [31:0]           wb_data_q;

   // Word index wraps, low bits pick the byte lane
   assign word_idx = exe.value[`RV_DMEM_AW+1:2];
   assign byte_off = exe.value[1:0];
   assign is_store = exe.valid && exe.cls == OPC_STORE;

   // Store lanes, offsets beyond the access size are ignored
   always_comb begin
      case (mem_size_e'(exe.funct3[1:0]))
         MEM_B: begin
            byte_en = 4'b0001 << byte_off;
            wdata   = {4{exe.store_data[7:0]}};
         end
         MEM_H: begin
            byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
            wdata   = {2{exe.store_data[15:0]}};
         end
         default: begin
            byte_en = 4'b1111;
            wdata   = exe.store_data;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (is_store && byte_en[i]) begin
            mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
         end
      end
   end

   // Combinational read sees a store from the previous cycle
   assign rdata = mem[word_idx];

   always_comb begin
      case (mem_size_e'(exe.funct3[1:0]))
         MEM_B: begin
            lane   = rdata >> {byte_off, 3'b000};
            ld_val = exe.funct3[2] ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
         end
         MEM_H: begin
            lane   = rdata >> {byte_off[1], 4'b0000};
            ld_val = exe.funct3[2] ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
         end
         default: begin
            lane   = rdata;
            ld_val = rdata;
         end
      endcase
   end

   assign wb_en = exe.valid && exe.rd != 5'd0 &&
                  (exe.cls == OPC_ALU_R || exe.cls == OPC_ALU_I || exe.cls == OPC_LOAD);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_valid_q <= 1'b0;
         br_valid   <= 1'b0;
         illegal    <= 1'b0;
      end else begin
         wb_valid_q <= wb_en;
         br_valid   <= exe.valid && exe.cls == OPC_BRANCH;
         illegal    <= exe.valid && exe.cls == OPC_ILLEGAL;
      end
   end

   always_ff @(posedge clk) begin
      if (wb_en) begin
         wb_rd_q   <= exe.rd;
         wb_data_q <= (exe.cls == OPC_LOAD) ? ld_val : exe.value;
      end
      if (exe.valid && exe.cls == OPC_BRANCH) begin
         br_taken  <= exe.taken;
         br_offset <= exe.offset;
      end
   end

   assign wb = '{valid: wb_valid_q, rd: wb_rd_q, data: wb_data_q};

endmodule

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        instr_valid,
   input  instr_u      instr,
   output logic        wb_valid,
   output logic [4:0]  wb_rd,
   output logic [31:0] wb_data,
   output logic        br_valid,
   output logic        br_taken,
   output logic [31:0] br_offset,
   output logic        illegal
);

   dec_op_t  dec;
   exe_res_t exe;
   wb_t      wb;   // Also the register file write port

   instr_decoder decode_i (
      .clk,
      .rst_n,
      .instr_valid,
      .instr,
      .dec
   );

   execute_unit execute_i (
      .clk,
      .rst_n,
      .dec,
      .wb,
      .exe
   );

   result_unit result_i (
      .clk,
      .rst_n,
      .exe,
      .wb,
      .br_valid,
      .br_taken,
      .br_offset,
      .illegal
   );

   assign wb_valid = wb.valid;
   assign wb_rd    = wb.rd;
   assign wb_data  = wb.data;

endmodule

// ==== verif/rv_core_checker.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_checker (
   input logic       clk,
   input logic       rst_n,
   input logic       instr_valid,
   input logic       wb_valid,
   input logic [4:0] wb_rd,
   input logic       br_valid,
   input logic       illegal
);

   logic strobe;

   assign strobe = wb_valid || br_valid || illegal;

   // Every strobe belongs to an instruction sampled exactly the pipeline latency earlier
   strobe_latency: assert property (@(posedge clk) disable iff (!rst_n)
      strobe |-> $past(instr_valid, `RV_PIPE_LATENCY))
      else $error("Output strobe without an instruction %0d cycles earlier", `RV_PIPE_LATENCY);

   strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({wb_valid, br_valid, illegal}))
      else $error("More than one output strobe high in the same cycle");

   wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid |-> wb_rd != 5'd0)
      else $error("Writeback strobe with rd equal to x0");

endmodule

bind rv_core_top rv_core_checker checker_i (
   .clk         (clk),
   .rst_n       (rst_n),
   .instr_valid (instr_valid),
   .wb_valid    (wb_valid),
   .wb_rd       (wb_rd),
   .br_valid    (br_valid),
   .illegal     (illegal)
);

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_tb import rv_core_pkg::*; ();

   localparam logic [1:0] K_WB  = 2'd0;
   localparam logic [1:0] K_BR  = 2'd1;
   localparam logic [1:0] K_ILL = 2'd2;
   localparam logic [39:0] R_OPS  = 40'h76D5432180;   // {alt, funct3} per R-type op
   localparam logic [14:0] LD_OPS = {3'd4, 3'd0, 3'd5, 3'd1, 3'd2};
   localparam logic [17:0] BR_OPS = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};

   typedef struct packed {
      logic [1:0]  kind;
      logic [4:0]  rd;
      logic [31:0] data;
      logic        taken;
      logic [31:0] offset;
      logic [31:0] due;     // Cycle at which the strobe must be seen
   } exp_t;

   logic        clk;
   logic        rst_n;
   logic        instr_valid;
   instr_u      instr;
   logic        wb_valid;
   logic [4:0]  wb_rd;
   logic [31:0] wb_data;
   logic        br_valid;
   logic        br_taken;
   logic [31:0] br_offset;
   logic        illegal;

   logic [31:0] sregs [32];    // Architectural register model
   logic [7:0]  smem [256];    // Byte-lane data memory model
   exp_t        q [$];
   int unsigned cyc = 0;
   int unsigned n_issued = 0;
   int unsigned errors = 0;
   int unsigned checks = 0;

   rv_core_top dut_i (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   function automatic logic [31:0] sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   // RV32I integer semantics
   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic issue(input logic [31:0] w, input logic exp_on, input exp_t e);
      exp_t x;
      x = e;
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= w;
      n_issued++;
      if (exp_on) begin
         x.due = cyc + `RV_PIPE_LATENCY + 1;   // DUT samples one edge after the drive
         q.push_back(x);
      end
   endtask

   task automatic op_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
      exp_t e;
      e      = '0;
      e.kind = K_WB;
      e.rd   = rd;
      e.data = alu_ref(f3, f3 == 3'd5 && imm[10], sregs[rs1], sext12(imm));
      if (rd != 5'd0) sregs[rd] = e.data;
      issue(enc_i(imm, rs1, f3, rd, 7'b0010011), rd != 5'd0, e);
   endtask

   task automatic op_reg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
      exp_t e;
      e      = '0;
      e.kind = K_WB;
      e.rd   = rd;
      e.data = alu_ref(f3, alt, sregs[rs1], sregs[rs2]);
      if (rd != 5'd0) sregs[rd] = e.data;
      issue(enc_r(alt, rs2, rs1, f3, rd), rd != 5'd0, e);
   endtask

   task automatic mem_load(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm);
      exp_t        e;
      logic [31:0] sum;
      logic [7:0]  a;
      logic [15:0] h;
      sum = sregs[rs1] + sext12(imm);
      a   = sum[7:0];   // 256-byte memory wraps
      e      = '0;
      e.kind = K_WB;
      e.rd   = rd;
      case (f3[1:0])
         2'd0: e.data = f3[2] ? {24'b0, smem[a]} : {{24{smem[a][7]}}, smem[a]};
         2'd1: begin
            a[0]   = 1'b0;
            h      = {smem[a + 8'd1], smem[a]};
            e.data = f3[2] ? {16'b0, h} : {{16{h[15]}}, h};
         end
         default: begin
            a[1:0] = 2'b00;
            e.data = {smem[a + 8'd3], smem[a + 8'd2], smem[a + 8'd1], smem[a]};
         end
      endcase
      if (rd != 5'd0) sregs[rd] = e.data;
      issue(enc_i(imm, rs1, f3, rd, 7'b0000011), rd != 5'd0, e);
   endtask

   task automatic mem_store(input logic [2:0] f3, input logic [4:0] rs2, input logic [4:0] rs1,
                            input logic [11:0] imm);
      logic [31:0] sum;
      logic [31:0] d;
      logic [7:0]  a;
      sum = sregs[rs1] + sext12(imm);
      a   = sum[7:0];
      d   = sregs[rs2];
      if (f3[1:0] == 2'd1) a[0] = 1'b0;
      if (f3[1:0] == 2'd2) a[1:0] = 2'b00;
      smem[a] = d[7:0];
      if (f3[1:0] != 2'd0) smem[a + 8'd1] = d[15:8];
      if (f3[1:0] == 2'd2) begin
         smem[a + 8'd2] = d[23:16];
         smem[a + 8'd3] = d[31:24];
      end
      issue(enc_s(imm, rs2, rs1, f3), 1'b0, '0);
   endtask

   task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [12:0] off);
      exp_t e;
      e        = '0;
      e.kind   = K_BR;
      e.taken  = branch_ref(f3, sregs[rs1], sregs[rs2]);
      e.offset = {{19{off[12]}}, off};
      issue(enc_b(off, rs2, rs1, f3), 1'b1, e);
   endtask

   task automatic read_regs();
      for (int k = 1; k < 32; k++) op_imm(3'd0, 5'(k), 5'(k), 12'd0);
   endtask

   task automatic drain();
      @(posedge clk);
      instr_valid <= 1'b0;
      while (q.size() > 0) @(posedge clk);
      repeat (2) @(posedge clk);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      errors++;
      $display("Error %s: expected 0x%h got 0x%h", name, exp, got);
   endtask

   task automatic compare_strobe(input exp_t e);
      assert (wb_valid == (e.kind == K_WB)) else report_mismatch("wb_valid",
         32'(e.kind == K_WB), 32'(wb_valid));
      assert (br_valid == (e.kind == K_BR)) else report_mismatch("br_valid",
         32'(e.kind == K_BR), 32'(br_valid));
      assert (illegal == (e.kind == K_ILL)) else report_mismatch("illegal",
         32'(e.kind == K_ILL), 32'(illegal));
      if (e.kind == K_WB && wb_valid) begin
         assert (wb_rd == e.rd) else report_mismatch("wb_rd", 32'(e.rd), 32'(wb_rd));
         assert (wb_data == e.data) else report_mismatch("wb_data", e.data, wb_data);
      end
      if (e.kind == K_BR && br_valid) begin
         assert (br_taken == e.taken) else report_mismatch("br_taken", 32'(e.taken),
            32'(br_taken));
         assert (br_offset == e.offset) else report_mismatch("br_offset", e.offset, br_offset);
      end
   endtask

   task automatic check_outputs();
      exp_t e;
      logic strobe;
      strobe = wb_valid || br_valid || illegal;
      if (q.size() > 0 && q[0].due <= cyc) begin
         e = q.pop_front();
         checks++;
         assert (strobe) else begin
            errors++;
            $display("Missing output strobe for the instruction due at cycle %0d", e.due);
         end
         if (strobe) compare_strobe(e);
      end else begin
         assert (!strobe) else begin
            errors++;
            $display("Output strobe at cycle %0d with no instruction due", cyc);
         end
      end
   endtask

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (rst_n) check_outputs();
   end

   task automatic test_imm_ops();
      for (int r = 1; r < 5; r++) op_imm(3'd0, 5'(r), 5'd0, 12'($urandom));
      for (int f = 0; f < 8; f++) begin
         if (f != 1 && f != 5) op_imm(3'(f), 5'(5 + f), 5'($urandom_range(4, 1)), 12'($urandom));
      end
      op_imm(3'd1, 5'd14, 5'd1, {7'b0, 5'($urandom)});         // SLLI
      op_imm(3'd5, 5'd15, 5'd2, {7'b0, 5'($urandom)});         // SRLI
      op_imm(3'd5, 5'd16, 5'd3, {7'b0100000, 5'($urandom)});   // SRAI
      op_imm(3'd0, 5'd0, 5'd1, 12'($urandom));                 // x0 target, no strobe
      drain();
   endtask

   task automatic test_reg_ops();
      op_imm(3'd0, 5'd5, 5'd0, 12'($urandom));
      op_imm(3'd0, 5'd6, 5'd0, 12'($urandom));
      // Each op consumes the previous result straight from the bypass
      for (int i = 0; i < 10; i++) begin
         op_reg(R_OPS[4*i +: 3], R_OPS[4*i+3], 5'd7, (i == 0) ? 5'd5 : 5'd7, 5'd6);
      end
      drain();
   endtask

   task automatic loads_after();
      for (int k = 0; k < 5; k++) begin
         mem_load(LD_OPS[3*k +: 3], 5'(10 + k), 5'd8, 12'($urandom_range(3, 0)));
      end
   endtask

   task automatic test_mem();
      for (int rep = 0; rep < 4; rep++) begin
         op_imm(3'd0, 5'd8, 5'd0, {4'b0, 6'($urandom), 2'b00});
         op_imm(3'd0, 5'd9, 5'd0, 12'($urandom));
         op_imm(3'd1, 5'd9, 5'd9, {7'b0, 5'($urandom_range(20, 0))});
         mem_store(3'd2, 5'd9, 5'd8, 12'd0);
         loads_after();
         op_imm(3'd4, 5'd9, 5'd9, 12'($urandom));
         mem_store(3'd1, 5'd9, 5'd8, 12'($urandom_range(3, 0)));
         loads_after();
         mem_store(3'd0, 5'd9, 5'd8, 12'($urandom_range(3, 0)));
         loads_after();
      end
      drain();
   endtask

   task automatic all_branches();
      for (int k = 0; k < 6; k++) begin
         branch(BR_OPS[3*k +: 3], 5'd1, 5'd2, {12'($urandom), 1'b0});
      end
   endtask

   task automatic test_branches();
      op_imm(3'd0, 5'd1, 5'd0, 12'd7);
      op_imm(3'd0, 5'd2, 5'd0, 12'd7);
      all_branches();
      op_imm(3'd0, 5'd1, 5'd0, 12'd3);
      op_imm(3'd0, 5'd2, 5'd0, 12'd9);
      all_branches();
      op_imm(3'd0, 5'd1, 5'd0, 12'd9);
      op_imm(3'd0, 5'd2, 5'd0, 12'd3);
      all_branches();
      op_imm(3'd0, 5'd1, 5'd0, 12'hFFF);   // -1 against 1
      op_imm(3'd0, 5'd2, 5'd0, 12'd1);
      all_branches();
      op_imm(3'd1, 5'd1, 5'd2, 12'd31);    // 0x80000000
      op_imm(3'd0, 5'd2, 5'd0, 12'hFFF);
      op_imm(3'd5, 5'd2, 5'd2, 12'd1);     // 0x7fffffff
      all_branches();
      op_reg(3'd0, 1'b0, 5'd3, 5'd1, 5'd0);
      op_reg(3'd0, 1'b0, 5'd1, 5'd2, 5'd0);
      op_reg(3'd0, 1'b0, 5'd2, 5'd3, 5'd0);
      all_branches();
      drain();
   endtask

   function automatic logic supported(input logic [6:0] op);
      return op == 7'b0110011 || op == 7'b0010011 || op == 7'b0000011 ||
             op == 7'b0100011 || op == 7'b1100011;
   endfunction

   task automatic test_illegal();
      logic [31:0] w;
      exp_t        e;
      e      = '0;
      e.kind = K_ILL;
      repeat (8) begin
         w = $urandom;
         while (supported(w[6:0])) w = $urandom;
         issue(w, 1'b1, e);
      end
      read_regs();
      drain();
   endtask

   task automatic test_reset();
      for (int r = 1; r < 6; r++) op_imm(3'd0, 5'(r), 5'd0, 12'($urandom));
      @(posedge clk);
      rst_n       <= 1'b0;
      instr_valid <= 1'b0;
      repeat (3) @(posedge clk);
      assert (!wb_valid && !br_valid && !illegal) else begin
         errors++;
         $display("Output strobes still high while reset is held");
      end
      q.delete();
      for (int k = 0; k < 32; k++) sregs[k] = '0;
      @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      read_regs();
      drain();
   endtask

   // Run limit grows with the number of issued instructions
   initial begin
      @(posedge clk);
      while (cyc < 4 * n_issued + 200) @(posedge clk);
      $display("Timeout: run stopped at cycle %0d with %0d instructions pending", cyc, q.size());
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      void'($urandom(32'hd19bb279));
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      for (int k = 0; k < 32; k++) sregs[k] = '0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      test_imm_ops();
      test_reg_ops();
      test_mem();
      test_branches();
      test_illegal();
      test_reset();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== rv_core.f ====
+incdir+hw
hw/rv_core_pkg.sv
hw/instr_decoder.sv
hw/execute_unit.sv
hw/result_unit.sv
hw/rv_core_top.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
echo "$out"

if echo "$out" | grep -q "PASS: all tests"; then
   exit 0
else
   exit 1
fi
